/* immu_top.f */
+incdir+design
+incdir+bench
design/sv39_pkg.sv
design/immu_bus_pkg.sv
design/immu_csr_regs.sv
design/itlb_array.sv
design/ptw_miss_fsm.sv
design/fetch_translate.sv
design/immu_top.sv
bench/tb_immu_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f immu_top.f --top-module tb_immu_top \
    -Mdir obj_dir -o sim_immu
./obj_dir/sim_immu > sim.log
cat sim.log
grep -q "^test passed$" sim.log

/* bench/immu_tests.svh */
`ifndef IMMU_TESTS_SVH
`define IMMU_TESTS_SVH

// ****************************************
// apb and fetch drivers
// ****************************************
task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel      = 1'b1;
    pwrite    = 1'b1;
    paddr_apb = addr;
    pwdata    = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic read_reg(input logic [3:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    psel      = 1'b1;
    pwrite    = 1'b0;
    paddr_apb = addr;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    check_value("pready", 64'(pready), 64'd1);
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic set_satp(input logic [3:0] mode, input logic [`ASID_W-1:0] asid);
    write_reg(`CSR_SATP, {mode, 12'd0, asid});
    cur_asid = asid;
endtask

function automatic logic [63:0] make_va(input logic [26:0] vpn, input logic [11:0] ofs);
    return {25'd0, vpn, ofs};
endfunction

// ppn is the page number plus 0x1000, zero-extended
function automatic logic [63:0] expected_paddr(input logic [26:0] vpn, input logic [11:0] ofs);
    return {8'd0, {17'd0, vpn} + 44'h1000, ofs};
endfunction

task automatic run_fetch(input logic [63:0] va, output logic [63:0] pa, output logic err,
                         output logic missed);
    int waited;
    int misses_before;
    misses_before = miss_count;
    waited        = 0;
    @(negedge clk);
    mmu_fifo_valid = 1'b1;
    vaddr          = va;
    #(CLK_PERIOD / 4);
    while (!mmu_fifo_ready && waited < FETCH_LIMIT) begin
        @(negedge clk);
        #(CLK_PERIOD / 4);
        waited++;
    end
    if (!mmu_fifo_ready) begin
        errors++;
        $display("fetch of %h was never accepted", va);
    end
    @(negedge clk);
    mmu_fifo_valid = 1'b0;
    check_value("paddr_valid", 64'(paddr_valid), 64'd1);
    pa     = fetch_resp.paddr;
    err    = fetch_resp.err;
    missed = (miss_count != misses_before);
endtask

task automatic fetch_and_check(input logic [26:0] vpn, input logic [11:0] ofs,
                               input logic exp_miss, input logic exp_err);
    logic [63:0] pa;
    logic        err;
    logic        missed;
    run_fetch(make_va(vpn, ofs), pa, err, missed);
    check_value("immu_miss_valid", 64'(missed), 64'(exp_miss));
    check_value("fetch_resp.err", 64'(err), 64'(exp_err));
    if (exp_miss) begin
        check_value("miss_vaddr", seen_miss_vaddr, make_va(vpn, ofs));
    end
    if (!exp_err) begin
        check_value("fetch_resp.paddr", pa, expected_paddr(vpn, ofs));
    end
endtask

// ****************************************
// directed tests
// ****************************************
task automatic bypass_and_config();
    logic [31:0] rd;
    logic        err;
    logic [63:0] pa;
    logic        perr;
    logic        missed;
    read_reg(`CSR_PRIV, rd, err);
    check_value("prdata", 64'(rd), 64'd0);
    read_reg(`CSR_SATP, rd, err);
    check_value("prdata", 64'(rd), 64'd0);
    check_value("pslverr", 64'(err), 64'd0);
    // user privilege, bare mode
    run_fetch(64'hfedc_ba98_7654_3210, pa, perr, missed);
    check_value("fetch_resp.paddr", pa, 64'hfedc_ba98_7654_3210);
    check_value("fetch_resp.err", 64'(perr), 64'd0);
    check_value("immu_miss_valid", 64'(missed), 64'd0);
    write_reg(`CSR_PRIV, 32'd3);
    set_satp(4'h8, 16'h0005);
    read_reg(`CSR_PRIV, rd, err);
    check_value("prdata", 64'(rd), 64'd3);
    read_reg(`CSR_SATP, rd, err);
    check_value("prdata", 64'(rd), 64'h8000_0005);
    // machine mode ignores satp
    run_fetch(64'h0000_1234_5678_9abc, pa, perr, missed);
    check_value("fetch_resp.paddr", pa, 64'h0000_1234_5678_9abc);
    check_value("fetch_resp.err", 64'(perr), 64'd0);
    check_value("immu_miss_valid", 64'(missed), 64'd0);
    read_reg(`CSR_FLUSH, rd, err);
    check_value("prdata", 64'(rd), 64'd0);
    check_value("pslverr", 64'(err), 64'd0);
    read_reg(4'hc, rd, err);
    check_value("pslverr", 64'(err), 64'd1);
endtask

task automatic miss_then_hit();
    write_reg(`CSR_PRIV, 32'd1);
    set_satp(4'h8, 16'h0001);
    fetch_and_check(27'h1, 12'h234, 1'b1, 1'b0);
    fetch_and_check(27'h1, 12'h568, 1'b0, 1'b0);
    fetch_and_check(27'h6, 12'hffc, 1'b1, 1'b0);
    fetch_and_check(27'h6, 12'h000, 1'b0, 1'b0);
endtask

task automatic error_cases();
    logic [63:0] pa;
    logic        perr;
    logic        missed;
    // bit 39 differs from bit 38
    run_fetch(64'h0000_0080_0000_0000, pa, perr, missed);
    check_value("fetch_resp.err", 64'(perr), 64'd1);
    check_value("immu_miss_valid", 64'(missed), 64'd0);
    page_table[2].exec = 1'b0;
    fetch_and_check(27'h2, 12'h010, 1'b1, 1'b1);
    fetch_and_check(27'h2, 12'h018, 1'b0, 1'b1);
    page_table[3].user = 1'b1;
    fetch_and_check(27'h3, 12'h020, 1'b1, 1'b1);
    page_table[4].err = 1'b1;
    fetch_and_check(27'h4, 12'h030, 1'b1, 1'b1);
    // faulting walk left nothing behind
    fetch_and_check(27'h4, 12'h034, 1'b1, 1'b1);
endtask

task automatic asid_and_flush();
    page_table[5].glob = 1'b1;
    fetch_and_check(27'h5, 12'h100, 1'b1, 1'b0);
    set_satp(4'h8, 16'h0002);
    fetch_and_check(27'h1, 12'h200, 1'b1, 1'b0);
    fetch_and_check(27'h5, 12'h300, 1'b0, 1'b0);
    write_reg(`CSR_FLUSH, 32'd1);
    fetch_and_check(27'h1, 12'h400, 1'b1, 1'b0);
    fetch_and_check(27'h5, 12'h500, 1'b1, 1'b0);
endtask

task automatic replacement_and_backpressure();
    logic [63:0] held;
    write_reg(`CSR_FLUSH, 32'd1);
    for (int i = 0; i < 9; i++) begin
        fetch_and_check(27'h10 + 27'(i), 12'h000, 1'b1, 1'b0);
    end
    // ninth refill landed on the first page's slot
    fetch_and_check(27'h11, 12'h008, 1'b0, 1'b0);
    fetch_and_check(27'h10, 12'h008, 1'b1, 1'b0);

    @(negedge clk);
    paddr_ready    = 1'b0;
    mmu_fifo_valid = 1'b1;
    vaddr          = make_va(27'h10, 12'h040);
    #(CLK_PERIOD / 4);
    check_value("mmu_fifo_ready", 64'(mmu_fifo_ready), 64'd1);
    @(negedge clk);
    vaddr = make_va(27'h10, 12'h080);
    held  = fetch_resp.paddr;
    check_value("fetch_resp.paddr", held, expected_paddr(27'h10, 12'h040));
    repeat (4) begin
        #(CLK_PERIOD / 4);
        check_value("paddr_valid", 64'(paddr_valid), 64'd1);
        check_value("fetch_resp.paddr", fetch_resp.paddr, held);
        check_value("fetch_resp.err", 64'(fetch_resp.err), 64'd0);
        check_value("mmu_fifo_ready", 64'(mmu_fifo_ready), 64'd0);
        @(negedge clk);
    end
    paddr_ready = 1'b1;
    #(CLK_PERIOD / 4);
    check_value("mmu_fifo_ready", 64'(mmu_fifo_ready), 64'd1);
    @(negedge clk);
    mmu_fifo_valid = 1'b0;
    check_value("paddr_valid", 64'(paddr_valid), 64'd1);
    check_value("fetch_resp.paddr", fetch_resp.paddr, expected_paddr(27'h10, 12'h080));
    @(negedge clk);
    check_value("paddr_valid", 64'(paddr_valid), 64'd0);
endtask

`endif

/* bench/tb_immu_top.sv */
`default_nettype none

`include "immu_consts.svh"

module tb_immu_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TESTS   = 5;
    localparam int FETCH_LIMIT = 200;

    // flags the second-level tlb hands out per page
    typedef struct packed {
        logic exec;
        logic user;
        logic glob;
        logic err;
    } page_attr_t;

    logic                      clk;
    logic                      rst_n;
    logic                      flush_flag;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [3:0]                paddr_apb;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      mmu_fifo_valid;
    logic                      mmu_fifo_ready;
    logic [`VADDR_W-1:0]       vaddr;
    logic                      paddr_valid;
    logic                      paddr_ready;
    immu_bus_pkg::fetch_resp_t fetch_resp;
    logic                      immu_miss_valid;
    logic                      immu_miss_ready;
    logic [`VADDR_W-1:0]       miss_vaddr;
    logic                      pte_valid;
    immu_bus_pkg::walk_resp_t  pte_resp;

    page_attr_t          page_table [32];
    logic [`ASID_W-1:0]  cur_asid;
    logic [`VADDR_W-1:0] seen_miss_vaddr;
    int                  miss_count;
    int                  errors;
    int                  checks;
    int                  seed = 30833;

    immu_top i_immu_top (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    `include "immu_tests.svh"

    // ****************************************
    // second-level tlb model
    // ****************************************
    initial begin : l2_tlb_model
        int                delay;
        logic [`VPN_W-1:0] vpn;
        logic [`PPN_W-1:0] ppn;
        page_attr_t        attr;
        pte_valid = 1'b0;
        pte_resp  = '0;
        forever begin
            @(negedge clk);
            if (immu_miss_valid) begin
                miss_count++;
                seen_miss_vaddr = miss_vaddr;
                vpn   = miss_vaddr[`SV39_TOP:`PAGE_OFS_W];
                ppn   = {17'd0, vpn} + 44'h1000;
                attr  = page_table[vpn[4:0]];
                delay = {$random(seed)} % 4;
                // request handshake ends at the next edge
                repeat (1 + delay) @(negedge clk);
                pte_resp  = {cur_asid, ppn, attr.glob, attr.user, attr.exec, vpn, attr.err};
                pte_valid = 1'b1;
                @(negedge clk);
                pte_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish within %0d cycles", NUM_TESTS * 2000);
        $display("test failed");
        $finish;
    end

    initial begin
        errors          = 0;
        checks          = 0;
        miss_count      = 0;
        cur_asid        = '0;
        seen_miss_vaddr = '0;
        rst_n           = 1'b0;
        flush_flag      = 1'b0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr_apb       = '0;
        pwdata          = '0;
        mmu_fifo_valid  = 1'b0;
        vaddr           = '0;
        paddr_ready     = 1'b1;
        immu_miss_ready = 1'b1;
        for (int i = 0; i < 32; i++) begin
            page_table[i] = '{exec: 1'b1, user: 1'b0, glob: 1'b0, err: 1'b0};
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_value("paddr_valid", 64'(paddr_valid), 64'd0);
        check_value("immu_miss_valid", 64'(immu_miss_valid), 64'd0);
        check_value("pslverr", 64'(pslverr), 64'd0);

        bypass_and_config();
        miss_then_hit();
        error_cases();
        asid_and_flush();
        replacement_and_backpressure();

        repeat (2) @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/immu_top.sv */
`default_nettype none

`include "immu_consts.svh"

module immu_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_flag,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [3:0]                paddr_apb,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      mmu_fifo_valid,
    output logic                      mmu_fifo_ready,
    input  logic [`VADDR_W-1:0]       vaddr,
    output logic                      paddr_valid,
    input  logic                      paddr_ready,
    output immu_bus_pkg::fetch_resp_t fetch_resp,
    output logic                      immu_miss_valid,
    input  logic                      immu_miss_ready,
    output logic [`VADDR_W-1:0]       miss_vaddr,
    input  logic                      pte_valid,
    input  immu_bus_pkg::walk_resp_t  pte_resp
);

    immu_bus_pkg::mmu_cfg_t   cfg;
    immu_bus_pkg::lookup_t    lookup;
    immu_bus_pkg::walk_resp_t walk_result;
    sv39_pkg::tlb_entry_t     refill_entry;
    logic                     flush;
    logic                     refill_wen;
    logic                     miss_start;
    logic                     fetch_accept;
    logic                     walk_done;

    immu_csr_regs i_immu_csr_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr_apb (paddr_apb),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cfg       (cfg),
        .flush     (flush)
    );

    itlb_array i_itlb_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .cfg          (cfg),
        .vaddr        (vaddr),
        .refill_wen   (refill_wen),
        .refill_entry (refill_entry),
        .lookup       (lookup)
    );

    ptw_miss_fsm i_ptw_miss_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_flag      (flush_flag),
        .miss_start      (miss_start),
        .vaddr           (vaddr),
        .immu_miss_ready (immu_miss_ready),
        .pte_valid       (pte_valid),
        .pte_resp        (pte_resp),
        .fetch_accept    (fetch_accept),
        .immu_miss_valid (immu_miss_valid),
        .miss_vaddr      (miss_vaddr),
        .refill_wen      (refill_wen),
        .refill_entry    (refill_entry),
        .walk_done       (walk_done),
        .walk_result     (walk_result)
    );

    fetch_translate i_fetch_translate (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_flag     (flush_flag),
        .cfg            (cfg),
        .mmu_fifo_valid (mmu_fifo_valid),
        .vaddr          (vaddr),
        .lookup         (lookup),
        .walk_done      (walk_done),
        .walk_result    (walk_result),
        .paddr_ready    (paddr_ready),
        .mmu_fifo_ready (mmu_fifo_ready),
        .miss_start     (miss_start),
        .fetch_accept   (fetch_accept),
        .paddr_valid    (paddr_valid),
        .fetch_resp     (fetch_resp)
    );

endmodule

`default_nettype wire

/* design/fetch_translate.sv */
`default_nettype none

`include "immu_consts.svh"

module fetch_translate (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_flag,
    input  immu_bus_pkg::mmu_cfg_t    cfg,
    input  logic                      mmu_fifo_valid,
    input  logic [`VADDR_W-1:0]       vaddr,
    input  immu_bus_pkg::lookup_t     lookup,
    input  logic                      walk_done,
    input  immu_bus_pkg::walk_resp_t  walk_result,
    input  logic                      paddr_ready,
    output logic                      mmu_fifo_ready,
    output logic                      miss_start,
    output logic                      fetch_accept,
    output logic                      paddr_valid,
    output immu_bus_pkg::fetch_resp_t fetch_resp
);

    localparam int EXT_W = `VADDR_W - 1 - `SV39_TOP;
    localparam int PAD_W = `PADDR_W - `PPN_W - `PAGE_OFS_W;

    logic                      bypass;
    logic                      canonical;
    logic                      can_go;
    logic                      out_free;
    logic                      miss_pending;
    logic [1:0]                priv_bits;
    sv39_pkg::tlb_entry_t      entry;
    immu_bus_pkg::fetch_resp_t next_resp;

    assign priv_bits = cfg.priv;
    assign bypass    = (cfg.priv == sv39_pkg::PRIV_M) || (cfg.mode == `SATP_BARE);
    assign canonical = (vaddr[`VADDR_W-1:`SV39_TOP+1] == {EXT_W{vaddr[`SV39_TOP]}});

    // walk answer takes precedence over the array
    assign entry = walk_done ? walk_result.entry : lookup.entry;

    assign can_go         = bypass || lookup.hit || !canonical || walk_done;
    assign out_free       = !paddr_valid || paddr_ready;
    assign mmu_fifo_ready = mmu_fifo_valid && can_go && out_free;
    assign fetch_accept   = mmu_fifo_valid && mmu_fifo_ready;
    assign miss_start     = mmu_fifo_valid && !bypass && canonical && !lookup.hit
                            && !walk_done && !miss_pending;

    // ****************************************
    // translation and fault checks
    // ****************************************
    always_comb begin
        if (bypass) begin
            next_resp.paddr = vaddr;
            next_resp.err   = 1'b0;
        end else begin
            next_resp.paddr = {{PAD_W{1'b0}}, entry.ppn, vaddr[`PAGE_OFS_W-1:0]};
            next_resp.err   = !canonical
                              || !entry.exec
                              || (priv_bits[0] == entry.user)
                              || (walk_done && walk_result.err);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paddr_valid  <= 1'b0;
            miss_pending <= 1'b0;
        end else if (flush_flag) begin
            paddr_valid  <= 1'b0;
            miss_pending <= 1'b0;
        end else begin
            if (out_free) begin
                paddr_valid <= fetch_accept;
            end
            // mirrors the sequencer being busy
            if (fetch_accept) begin
                miss_pending <= 1'b0;
            end else if (miss_start) begin
                miss_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            fetch_resp <= next_resp;
        end
    end

endmodule

`default_nettype wire

/* design/ptw_miss_fsm.sv */
`default_nettype none

`include "immu_consts.svh"

module ptw_miss_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_flag,
    input  logic                     miss_start,
    input  logic [`VADDR_W-1:0]      vaddr,
    input  logic                     immu_miss_ready,
    input  logic                     pte_valid,
    input  immu_bus_pkg::walk_resp_t pte_resp,
    input  logic                     fetch_accept,
    output logic                     immu_miss_valid,
    output logic [`VADDR_W-1:0]      miss_vaddr,
    output logic                     refill_wen,
    output sv39_pkg::tlb_entry_t     refill_entry,
    output logic                     walk_done,
    output immu_bus_pkg::walk_resp_t walk_result
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_WAIT = 2'd2,
        ST_DONE = 2'd3
    } state_e;

    state_e state;
    logic   resp_fire;

    assign resp_fire       = (state == ST_WAIT) && pte_valid;
    assign immu_miss_valid = (state == ST_REQ);
    assign walk_done       = (state == ST_DONE);

    // faulting walks are never cached
    assign refill_wen   = resp_fire && !pte_resp.err;
    assign refill_entry = pte_resp.entry;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else if (flush_flag) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (miss_start) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (immu_miss_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (pte_valid) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    // done, held until the fetch leaves
                    if (fetch_accept) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start && (state == ST_IDLE)) begin
            miss_vaddr <= vaddr;
        end
        if (resp_fire) begin
            walk_result <= pte_resp;
        end
    end

endmodule

`default_nettype wire

/* design/itlb_array.sv */
`default_nettype none

`include "immu_consts.svh"

module itlb_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  immu_bus_pkg::mmu_cfg_t cfg,
    input  logic [`VADDR_W-1:0]    vaddr,
    input  logic                   refill_wen,
    input  sv39_pkg::tlb_entry_t   refill_entry,
    output immu_bus_pkg::lookup_t  lookup
);

    localparam int PTR_W = $clog2(`ITLB_ENTRIES);

    sv39_pkg::tlb_entry_t     entries [`ITLB_ENTRIES];
    logic [`ITLB_ENTRIES-1:0] valid;
    logic [`ITLB_ENTRIES-1:0] hit_vec;
    logic [PTR_W-1:0]         victim;
    logic [`VPN_W-1:0]        vpn;

    assign vpn = vaddr[`SV39_TOP:`PAGE_OFS_W];

    // ****************************************
    // parallel match
    // ****************************************
    always_comb begin
        for (int i = 0; i < `ITLB_ENTRIES; i++) begin
            hit_vec[i] = valid[i]
                && (entries[i].vpn == vpn)
                && (entries[i].glob || (entries[i].asid == cfg.asid));
        end
    end

    // one-hot or-mux, at most one entry matches
    always_comb begin
        lookup.hit   = |hit_vec;
        lookup.entry = '0;
        for (int i = 0; i < `ITLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                lookup.entry = lookup.entry | entries[i];
            end
        end
    end

    // ****************************************
    // refill and round-robin victim
    // ****************************************
    always_ff @(posedge clk) begin
        if (refill_wen) begin
            entries[victim] <= refill_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid  <= '0;
            victim <= '0;
        end else begin
            if (flush) begin
                valid <= '0;
            end else if (refill_wen) begin
                valid[victim] <= 1'b1;
            end
            // pointer survives a flush
            if (refill_wen) begin
                if (victim == PTR_W'(`ITLB_ENTRIES - 1)) begin
                    victim <= '0;
                end else begin
                    victim <= victim + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/immu_csr_regs.sv */
`default_nettype none

`include "immu_consts.svh"

module immu_csr_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [3:0]             paddr_apb,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output immu_bus_pkg::mmu_cfg_t cfg,
    output logic                   flush
);

    logic access;
    logic wr_en;
    logic bad_addr;

    assign access  = psel & penable;
    assign wr_en   = access & pwrite;
    assign pready  = 1'b1;
    assign pslverr = access & bad_addr;

    // readback, satp keeps mode in the top nibble
    always_comb begin
        bad_addr = 1'b0;
        prdata   = '0;
        case (paddr_apb)
            `CSR_PRIV: prdata = {30'd0, cfg.priv};
            `CSR_SATP: prdata = {cfg.mode, 12'd0, cfg.asid};
            `CSR_FLUSH: prdata = '0;
            default: bad_addr = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg   <= '0;
            flush <= 1'b0;
        end else begin
            // single-cycle pulse after the access phase
            flush <= wr_en && (paddr_apb == `CSR_FLUSH);
            if (wr_en && (paddr_apb == `CSR_PRIV)) begin
                cfg.priv <= sv39_pkg::priv_e'(pwdata[1:0]);
            end
            if (wr_en && (paddr_apb == `CSR_SATP)) begin
                cfg.mode <= pwdata[31:28];
                cfg.asid <= pwdata[`ASID_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* design/immu_bus_pkg.sv */
`default_nettype none

`include "immu_consts.svh"

package immu_bus_pkg;

    // from the apb register block
    typedef struct packed {
        sv39_pkg::priv_e    priv;
        logic [3:0]         mode;
        logic [`ASID_W-1:0] asid;
    } mmu_cfg_t;

    // answer of the second-level tlb
    typedef struct packed {
        sv39_pkg::tlb_entry_t entry;
        logic                 err;
    } walk_resp_t;

    // toward the icache
    typedef struct packed {
        logic [`PADDR_W-1:0] paddr;
        logic                err;
    } fetch_resp_t;

    typedef struct packed {
        logic                 hit;
        sv39_pkg::tlb_entry_t entry;
    } lookup_t;

endpackage

`default_nettype wire

/* design/sv39_pkg.sv */
`default_nettype none

`include "immu_consts.svh"

package sv39_pkg;

    // privilege levels, 2 is reserved
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    // ****************************************
    // cached 4 KiB translation
    // ****************************************
    typedef struct packed {
        logic [`ASID_W-1:0] asid;
        logic [`PPN_W-1:0]  ppn;
        logic               glob;
        logic               user;
        logic               exec;
        logic [`VPN_W-1:0]  vpn;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* design/immu_consts.svh */
`ifndef IMMU_CONSTS_SVH
`define IMMU_CONSTS_SVH

// tlb geometry
`define ITLB_ENTRIES 8

// sv39 address widths
`define VADDR_W      64
`define PADDR_W      64
`define VPN_W        27
`define PPN_W        44
`define ASID_W       16
`define PAGE_OFS_W   12
`define SV39_TOP     38

// apb register offsets
`define CSR_PRIV     4'h0
`define CSR_SATP     4'h4
`define CSR_FLUSH    4'h8

`define SATP_BARE    4'h0

`endif
